/* hw/a2_glue_pkg.sv */
package a2_glue_pkg;

    // Apple II data bus
    localparam int BUS_DATA_W = 8;

    // Audio source widths
    localparam int AUDIO_SRC_W = 10;
    localparam int AUDIO_EXT_W = 13;
    localparam int AUDIO_OUT_W = 16;

    // Speaker lands on the top bit of the extended word
    localparam int SPEAKER_SHIFT = 12;

    // 10-bit card audio moved up to the extended width
    localparam int SRC_SHIFT = 3;

    // Video
    localparam int COLOR_W = 8;
    localparam int SCREEN_COORD_W = 10;

    // Peripheral cards sharing the bus
    localparam int NUM_CARDS = 3;

    // Card positions in the read enable and IRQ vectors
    typedef enum logic [1:0] {
        CARD_SERIAL = 2'd0,
        CARD_SPRITE = 2'd1,
        CARD_SYNTH  = 2'd2
    } card_idx_e;

    typedef logic [BUS_DATA_W-1:0] bus_byte_t;

    typedef logic [AUDIO_OUT_W-1:0] audio_sample_t;

    typedef logic [COLOR_W-1:0] color_t;

endpackage

/* hw/bus_clock_sync.sv */
`timescale 1ns/1ps

module bus_clock_sync #(
    parameter int DENOISE_CYCLES = 2
) (
    input  logic clk_logic_w,
    input  logic system_reset_n_w,
    input  logic bus_clk_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    localparam int CNT_W = (DENOISE_CYCLES > 1) ? $clog2(DENOISE_CYCLES) : 1;

    logic [1:0] sync_r;
    logic [CNT_W-1:0] stable_cnt_r;
    logic sync_w;
    logic differs_w;
    logic accept_w;

    assign sync_w = sync_r[1];
    assign differs_w = (sync_w != level_o);
    // Synchronized value has disagreed with the level long enough
    assign accept_w = differs_w && (stable_cnt_r == CNT_W'(DENOISE_CYCLES - 1));

    // Two-flop synchronizer for the asynchronous bus clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            sync_r <= 2'b00;
        end else begin
            sync_r <= {sync_r[0], bus_clk_i};
        end
    end

    // Glitch filter, any return to the current level restarts the count
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            stable_cnt_r <= '0;
            level_o      <= 1'b0;
            rise_o       <= 1'b0;
            fall_o       <= 1'b0;
        end else begin
            rise_o <= accept_w && sync_w;
            fall_o <= accept_w && !sync_w;
            if (!differs_w || accept_w) begin
                stable_cnt_r <= '0;
            end else begin
                stable_cnt_r <= stable_cnt_r + 1'b1;
            end
            if (accept_w) begin
                level_o <= sync_w;
            end
        end
    end

endmodule

/* hw/card_bus_arbiter.sv */
`timescale 1ns/1ps

module card_bus_arbiter #(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE = 1'b1
) (
    input  logic                              clk_logic_w,
    input  logic                              system_reset_n_w,
    input  logic [a2_glue_pkg::NUM_CARDS-1:0] card_rd_en_i,
    input  a2_glue_pkg::bus_byte_t            serial_data_i,
    input  a2_glue_pkg::bus_byte_t            sprite_data_i,
    input  a2_glue_pkg::bus_byte_t            synth_data_i,
    input  a2_glue_pkg::bus_byte_t            bus_data_i,
    input  logic [a2_glue_pkg::NUM_CARDS-1:0] card_irq_n_i,
    output logic                              data_dir_o,
    output a2_glue_pkg::bus_byte_t            data_o,
    output logic                              irq_n_o
);

    import a2_glue_pkg::*;

    bus_byte_t data_next_w;
    logic dir_next_w;
    logic irq_n_next_w;

    // Fixed priority, serial card first
    always_comb begin
        if (card_rd_en_i[CARD_SERIAL]) begin
            data_next_w = serial_data_i;
        end else if (card_rd_en_i[CARD_SPRITE]) begin
            data_next_w = sprite_data_i;
        end else if (card_rd_en_i[CARD_SYNTH]) begin
            data_next_w = synth_data_i;
        end else begin
            // No card selected, echo the latched bus byte
            data_next_w = bus_data_i;
        end
    end

    // Drive the bus only when the build allows it
    assign dir_next_w = BUS_DATA_OUT_ENABLE && (|card_rd_en_i);

    // Open-drain style combine of the card interrupts
    assign irq_n_next_w = IRQ_OUT_ENABLE ? (&card_irq_n_i) : 1'b1;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            data_dir_o <= 1'b0;
            data_o     <= '0;
            irq_n_o    <= 1'b1;
        end else begin
            data_dir_o <= dir_next_w;
            data_o     <= data_next_w;
            irq_n_o    <= irq_n_next_w;
        end
    end

endmodule

/* hw/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer #(
    parameter bit SPEAKER_ENABLE = 1'b1
) (
    input  logic                                clk_logic_w,
    input  logic                                system_reset_n_w,
    input  logic                                speaker_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0] sprite_audio_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0] synth_left_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0] synth_right_i,
    input  a2_glue_pkg::audio_sample_t          i2s_left_i,
    input  a2_glue_pkg::audio_sample_t          i2s_right_i,
    output a2_glue_pkg::audio_sample_t          audio_left_o,
    output a2_glue_pkg::audio_sample_t          audio_right_o
);

    import a2_glue_pkg::*;

    logic [AUDIO_EXT_W-1:0] speaker_ext_w;
    logic [AUDIO_EXT_W-1:0] sprite_ext_w;
    logic [AUDIO_EXT_W-1:0] synth_left_ext_w;
    logic [AUDIO_EXT_W-1:0] synth_right_ext_w;
    audio_sample_t mix_left_w;
    audio_sample_t mix_right_w;

    // Speaker is a single bit, weighted at the top of the extended word
    assign speaker_ext_w = SPEAKER_ENABLE ?
        (AUDIO_EXT_W'(speaker_i) << SPEAKER_SHIFT) : '0;

    // Card sources are unsigned, scaled up to the extended width
    assign sprite_ext_w      = AUDIO_EXT_W'(sprite_audio_i) << SRC_SHIFT;
    assign synth_left_ext_w  = AUDIO_EXT_W'(synth_left_i) << SRC_SHIFT;
    assign synth_right_ext_w = AUDIO_EXT_W'(synth_right_i) << SRC_SHIFT;

    // Sums wrap at 16 bits
    assign mix_left_w = AUDIO_OUT_W'(speaker_ext_w) + AUDIO_OUT_W'(sprite_ext_w)
                      + AUDIO_OUT_W'(synth_left_ext_w) + i2s_left_i;
    assign mix_right_w = AUDIO_OUT_W'(speaker_ext_w) + AUDIO_OUT_W'(sprite_ext_w)
                       + AUDIO_OUT_W'(synth_right_ext_w) + i2s_right_i;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            audio_left_o  <= '0;
            audio_right_o <= '0;
        end else begin
            audio_left_o  <= mix_left_w;
            audio_right_o <= mix_right_w;
        end
    end

endmodule

/* hw/scanline_dimmer.sv */
`timescale 1ns/1ps

module scanline_dimmer (
    input  logic                                   clk_logic_w,
    input  logic                                   system_reset_n_w,
    input  logic                                   scanlines_en_i,
    input  logic [a2_glue_pkg::SCREEN_COORD_W-1:0] screen_y_i,
    input  a2_glue_pkg::color_t                    r_i,
    input  a2_glue_pkg::color_t                    g_i,
    input  a2_glue_pkg::color_t                    b_i,
    output a2_glue_pkg::color_t                    r_o,
    output a2_glue_pkg::color_t                    g_o,
    output a2_glue_pkg::color_t                    b_o
);

    import a2_glue_pkg::*;

    logic dim_w;

    // Odd lines only
    assign dim_w = scanlines_en_i && screen_y_i[0];

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else if (dim_w) begin
            // Half brightness, zero fill from the top
            r_o <= r_i >> 1;
            g_o <= g_i >> 1;
            b_o <= b_i >> 1;
        end else begin
            r_o <= r_i;
            g_o <= g_i;
            b_o <= b_i;
        end
    end

endmodule

/* hw/a2_card_glue.sv */
`timescale 1ns/1ps

module a2_card_glue #(
    parameter int DENOISE_CYCLES = 2,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE = 1'b1,
    parameter bit SPEAKER_ENABLE = 1'b1
) (
    input  logic                                   clk_logic_w,
    input  logic                                   system_reset_n_w,

    // Apple bus clocks
    input  logic                                   a2_phi1_i,
    input  logic                                   a2_q3_i,
    input  logic                                   a2_7m_i,

    // Recovered clocks and edges
    output logic                                   phi1_o,
    output logic                                   phi0_o,
    output logic                                   phi1_rise_o,
    output logic                                   phi1_fall_o,
    output logic                                   q3_rise_o,
    output logic                                   q3_fall_o,
    output logic                                   c7m_rise_o,
    output logic                                   c7m_fall_o,

    // Card read data and interrupts
    input  logic [a2_glue_pkg::NUM_CARDS-1:0]      card_rd_en_i,
    input  a2_glue_pkg::bus_byte_t                 serial_data_i,
    input  a2_glue_pkg::bus_byte_t                 sprite_data_i,
    input  a2_glue_pkg::bus_byte_t                 synth_data_i,
    input  a2_glue_pkg::bus_byte_t                 bus_data_i,
    input  logic [a2_glue_pkg::NUM_CARDS-1:0]      card_irq_n_i,
    output logic                                   data_dir_o,
    output a2_glue_pkg::bus_byte_t                 data_o,
    output logic                                   irq_n_o,

    // Audio
    input  logic                                   speaker_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0]    sprite_audio_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0]    synth_left_i,
    input  logic [a2_glue_pkg::AUDIO_SRC_W-1:0]    synth_right_i,
    input  a2_glue_pkg::audio_sample_t             i2s_left_i,
    input  a2_glue_pkg::audio_sample_t             i2s_right_i,
    output a2_glue_pkg::audio_sample_t             audio_left_o,
    output a2_glue_pkg::audio_sample_t             audio_right_o,

    // Video
    input  logic                                   scanlines_en_i,
    input  logic [a2_glue_pkg::SCREEN_COORD_W-1:0] screen_y_i,
    input  a2_glue_pkg::color_t                    r_i,
    input  a2_glue_pkg::color_t                    g_i,
    input  a2_glue_pkg::color_t                    b_i,
    output a2_glue_pkg::color_t                    r_o,
    output a2_glue_pkg::color_t                    g_o,
    output a2_glue_pkg::color_t                    b_o
);

    // Phi0 is the complement of phi1
    assign phi0_o = ~phi1_o;

    bus_clock_sync #(
        .DENOISE_CYCLES(DENOISE_CYCLES)
    ) u_phi1_sync (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .bus_clk_i       (a2_phi1_i),
        .level_o         (phi1_o),
        .rise_o          (phi1_rise_o),
        .fall_o          (phi1_fall_o)
    );

    // Only the edges of Q3 and 7M are needed
    bus_clock_sync #(
        .DENOISE_CYCLES(DENOISE_CYCLES)
    ) u_q3_sync (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .bus_clk_i       (a2_q3_i),
        .level_o         (),
        .rise_o          (q3_rise_o),
        .fall_o          (q3_fall_o)
    );

    bus_clock_sync #(
        .DENOISE_CYCLES(DENOISE_CYCLES)
    ) u_c7m_sync (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .bus_clk_i       (a2_7m_i),
        .level_o         (),
        .rise_o          (c7m_rise_o),
        .fall_o          (c7m_fall_o)
    );

    card_bus_arbiter #(
        .BUS_DATA_OUT_ENABLE(BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE     (IRQ_OUT_ENABLE)
    ) u_arbiter (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .card_rd_en_i    (card_rd_en_i),
        .serial_data_i   (serial_data_i),
        .sprite_data_i   (sprite_data_i),
        .synth_data_i    (synth_data_i),
        .bus_data_i      (bus_data_i),
        .card_irq_n_i    (card_irq_n_i),
        .data_dir_o      (data_dir_o),
        .data_o          (data_o),
        .irq_n_o         (irq_n_o)
    );

    audio_mixer #(
        .SPEAKER_ENABLE(SPEAKER_ENABLE)
    ) u_mixer (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .speaker_i       (speaker_i),
        .sprite_audio_i  (sprite_audio_i),
        .synth_left_i    (synth_left_i),
        .synth_right_i   (synth_right_i),
        .i2s_left_i      (i2s_left_i),
        .i2s_right_i     (i2s_right_i),
        .audio_left_o    (audio_left_o),
        .audio_right_o   (audio_right_o)
    );

    scanline_dimmer u_dimmer (
        .clk_logic_w     (clk_logic_w),
        .system_reset_n_w(system_reset_n_w),
        .scanlines_en_i  (scanlines_en_i),
        .screen_y_i      (screen_y_i),
        .r_i             (r_i),
        .g_i             (g_i),
        .b_i             (b_i),
        .r_o             (r_o),
        .g_o             (g_o),
        .b_o             (b_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100,
    parameter int RESET_CYCLES = 10,
    parameter int RELEASE_DELAY_NS = 10
) (
    output logic clk_logic_w,
    output logic system_reset_n_w
);

    initial begin
        clk_logic_w = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_logic_w = ~clk_logic_w;
        end
    end

    // Reset low for RESET_CYCLES rising edges, released just after an edge
    initial begin
        system_reset_n_w = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        #(RELEASE_DELAY_NS);
        system_reset_n_w = 1'b1;
    end

endmodule

/* tb/a2_card_glue_tb.sv */
`timescale 1ns/1ps

module a2_card_glue_tb;

    import a2_glue_pkg::*;

    localparam int PERIOD_NS = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY_NS = 10;
    localparam int RANDOM_CYCLES = 3000;
    localparam int DRAIN_CYCLES = 8;
    localparam int WATCHDOG_NS = (RESET_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES + 100) * PERIOD_NS;
    localparam int RANDOM_SEED = 32'hdf5a475e;
    localparam int DENOISE_CYCLES = 2;
    localparam int MIN_HALF_PERIOD = 6;
    localparam bit BUS_DATA_OUT_ENABLE = 1'b1;
    localparam bit IRQ_OUT_ENABLE = 1'b1;
    localparam bit SPEAKER_ENABLE = 1'b1;

    logic clk_logic_w;
    logic system_reset_n_w;
    logic a2_phi1_i, a2_q3_i, a2_7m_i;
    logic phi1_o, phi0_o, phi1_rise_o, phi1_fall_o;
    logic q3_rise_o, q3_fall_o, c7m_rise_o, c7m_fall_o;
    logic [NUM_CARDS-1:0] card_rd_en_i, card_irq_n_i;
    bus_byte_t serial_data_i, sprite_data_i, synth_data_i, bus_data_i, data_o;
    logic data_dir_o, irq_n_o;
    logic speaker_i;
    logic [AUDIO_SRC_W-1:0] sprite_audio_i, synth_left_i, synth_right_i;
    audio_sample_t i2s_left_i, i2s_right_i, audio_left_o, audio_right_o;
    logic scanlines_en_i;
    logic [SCREEN_COORD_W-1:0] screen_y_i;
    color_t r_i, g_i, b_i, r_o, g_o, b_o;

    // Reference state is updated on the rising edge and compared on the falling edge
    logic [DENOISE_CYCLES:0] clk_hist_r [3];
    logic [2:0] exp_level_r, exp_rise_r, exp_fall_r;
    logic [5:0] pulse_prev_r;
    logic phi1_last_r;
    int unsigned phi1_same_r;
    logic exp_dir_r, exp_irq_n_r;
    bus_byte_t exp_data_r;
    audio_sample_t exp_left_r, exp_right_r;
    color_t exp_r_r, exp_g_r, exp_b_r;

    // Bus clock generator state and coverage counts
    int unsigned half_left [3];
    logic [2:0] clk_level, glitch_on;
    int unsigned toggle_cnt [3];
    int unsigned arb_case_cnt [5];
    int unsigned glitch_cnt, wrap_cnt, speaker_cnt, dim_cnt, pass_cnt;

    logic [2:0] bus_clk_w, rise_w, fall_w;
    logic [5:0] pulses_w;

    assign bus_clk_w = {a2_7m_i, a2_q3_i, a2_phi1_i};
    assign rise_w = {c7m_rise_o, q3_rise_o, phi1_rise_o};
    assign fall_w = {c7m_fall_o, q3_fall_o, phi1_fall_o};
    assign pulses_w = {rise_w, fall_w};

    tb_clock_gen #(
        .PERIOD_NS       (PERIOD_NS),
        .RESET_CYCLES    (RESET_CYCLES),
        .RELEASE_DELAY_NS(DRIVE_DELAY_NS)
    ) u_clock_gen (.*);

    a2_card_glue #(
        .DENOISE_CYCLES     (DENOISE_CYCLES),
        .BUS_DATA_OUT_ENABLE(BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE     (IRQ_OUT_ENABLE),
        .SPEAKER_ENABLE     (SPEAKER_ENABLE)
    ) DUT (.*);

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_failure($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    task automatic require_seen(input int unsigned count, input string what);
        assert (count > 0) else stop_on_failure($sformatf("Stimulus never reached %s", what));
    endtask

    // Serial card first, then sprite, then synthesizer, else the latched byte
    function automatic bus_byte_t expected_bus_byte(input logic [NUM_CARDS-1:0] en,
        input bus_byte_t ser, input bus_byte_t spr, input bus_byte_t syn,
        input bus_byte_t latched);
        casez (en)
            3'b??1: return ser;
            3'b?10: return spr;
            3'b100: return syn;
            default: return latched;
        endcase
    endfunction

    // Speaker weighs 2^12 and the 10-bit sources are scaled by eight
    function automatic audio_sample_t expected_mix(input logic spk,
        input logic [AUDIO_SRC_W-1:0] card_src, input logic [AUDIO_SRC_W-1:0] synth_src,
        input audio_sample_t i2s);
        audio_sample_t spk_term;
        spk_term = (SPEAKER_ENABLE && spk) ? 16'h1000 : 16'h0000;
        return spk_term + audio_sample_t'(card_src) * 16'd8
             + audio_sample_t'(synth_src) * 16'd8 + i2s;
    endfunction

    function automatic color_t expected_channel(input logic en, input logic odd, input color_t c);
        return (en && odd) ? c / 8'd2 : c;
    endfunction

    always @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            for (int i = 0; i < 3; i++) begin
                clk_hist_r[i] <= '0;
            end
            exp_level_r <= '0;
            exp_rise_r <= '0;
            exp_fall_r <= '0;
            pulse_prev_r <= '0;
            phi1_last_r <= 1'b0;
            phi1_same_r <= 0;
            exp_dir_r <= 1'b0;
            exp_irq_n_r <= 1'b1;
            exp_data_r <= '0;
            exp_left_r <= '0;
            exp_right_r <= '0;
            exp_r_r <= '0;
            exp_g_r <= '0;
            exp_b_r <= '0;
        end else begin
            // Bits DENOISE_CYCLES..1 hold the synchronized samples that decide a change
            for (int i = 0; i < 3; i++) begin
                clk_hist_r[i] <= {clk_hist_r[i][DENOISE_CYCLES-1:0], bus_clk_w[i]};
                exp_rise_r[i] <= !exp_level_r[i] && (&clk_hist_r[i][DENOISE_CYCLES:1]);
                exp_fall_r[i] <= exp_level_r[i] && !(|clk_hist_r[i][DENOISE_CYCLES:1]);
                if (&clk_hist_r[i][DENOISE_CYCLES:1]) begin
                    exp_level_r[i] <= 1'b1;
                end else if (!(|clk_hist_r[i][DENOISE_CYCLES:1])) begin
                    exp_level_r[i] <= 1'b0;
                end
            end
            pulse_prev_r <= pulses_w;
            phi1_last_r <= a2_phi1_i;
            phi1_same_r <= (a2_phi1_i != phi1_last_r) ? 0 : phi1_same_r + 1;
            exp_dir_r <= BUS_DATA_OUT_ENABLE && (card_rd_en_i != '0);
            exp_irq_n_r <= IRQ_OUT_ENABLE ? (card_irq_n_i == '1) : 1'b1;
            exp_data_r <= expected_bus_byte(card_rd_en_i, serial_data_i, sprite_data_i,
                                            synth_data_i, bus_data_i);
            exp_left_r <= expected_mix(speaker_i, sprite_audio_i, synth_left_i, i2s_left_i);
            exp_right_r <= expected_mix(speaker_i, sprite_audio_i, synth_right_i, i2s_right_i);
            exp_r_r <= expected_channel(scanlines_en_i, screen_y_i[0], r_i);
            exp_g_r <= expected_channel(scanlines_en_i, screen_y_i[0], g_i);
            exp_b_r <= expected_channel(scanlines_en_i, screen_y_i[0], b_i);
        end
    end

    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        phi1_o == exp_level_r[0])
        else report_mismatch($sformatf("phi1_o=%0b expected %0b", phi1_o, exp_level_r[0]));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        phi0_o == !exp_level_r[0])
        else report_mismatch($sformatf("phi0_o=%0b expected %0b", phi0_o, !exp_level_r[0]));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        (phi1_same_r < DENOISE_CYCLES + 1) || (phi1_o == phi1_last_r))
        else report_mismatch("phi1_o did not follow a clean phi1 change in time");
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w) rise_w == exp_rise_r)
        else report_mismatch($sformatf("rise pulses %b expected %b", rise_w, exp_rise_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w) fall_w == exp_fall_r)
        else report_mismatch($sformatf("fall pulses %b expected %b", fall_w, exp_fall_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        (pulses_w & pulse_prev_r) == '0)
        else report_mismatch($sformatf("edge pulse held two cycles, %b", pulses_w));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w) data_o == exp_data_r)
        else report_mismatch($sformatf("data_o=%02h expected %02h", data_o, exp_data_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        data_dir_o == exp_dir_r)
        else report_mismatch($sformatf("data_dir_o=%0b expected %0b", data_dir_o, exp_dir_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        irq_n_o == exp_irq_n_r)
        else report_mismatch($sformatf("irq_n_o=%0b expected %0b", irq_n_o, exp_irq_n_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        audio_left_o == exp_left_r)
        else report_mismatch($sformatf("audio_left_o=%04h expected %04h",
                                       audio_left_o, exp_left_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        audio_right_o == exp_right_r)
        else report_mismatch($sformatf("audio_right_o=%04h expected %04h",
                                       audio_right_o, exp_right_r));
    assert property (@(negedge clk_logic_w) disable iff (!system_reset_n_w)
        {r_o, g_o, b_o} == {exp_r_r, exp_g_r, exp_b_r})
        else report_mismatch($sformatf("rgb=%06h expected %06h", {r_o, g_o, b_o},
                                       {exp_r_r, exp_g_r, exp_b_r}));

    // Square waves of random half-periods with isolated one-cycle glitches
    task automatic drive_bus_clocks();
        logic [2:0] drive;
        drive = '0;
        for (int i = 0; i < 3; i++) begin
            if (glitch_on[i]) begin
                glitch_on[i] = 1'b0;
                drive[i] = clk_level[i];
            end else if (half_left[i] == 0) begin
                clk_level[i] = !clk_level[i];
                half_left[i] = MIN_HALF_PERIOD + ($urandom % 8);
                toggle_cnt[i]++;
                drive[i] = clk_level[i];
            end else begin
                half_left[i]--;
                if (half_left[i] == 3 && ($urandom % 2) == 1) begin
                    glitch_on[i] = 1'b1;
                    glitch_cnt++;
                    drive[i] = !clk_level[i];
                end else begin
                    drive[i] = clk_level[i];
                end
            end
        end
        a2_phi1_i = drive[0];
        a2_q3_i = drive[1];
        a2_7m_i = drive[2];
    endtask

    task automatic drive_card_bus();
        card_rd_en_i = NUM_CARDS'($urandom);
        card_irq_n_i = NUM_CARDS'($urandom);
        serial_data_i = bus_byte_t'($urandom);
        sprite_data_i = bus_byte_t'($urandom);
        synth_data_i = bus_byte_t'($urandom);
        bus_data_i = bus_byte_t'($urandom);
        if (card_rd_en_i[CARD_SERIAL]) arb_case_cnt[0]++;
        else if (card_rd_en_i[CARD_SPRITE]) arb_case_cnt[1]++;
        else if (card_rd_en_i[CARD_SYNTH]) arb_case_cnt[2]++;
        else arb_case_cnt[3]++;
        if ($countones(card_rd_en_i) > 1) arb_case_cnt[4]++;
    endtask

    task automatic drive_audio();
        if (($urandom % 8) == 0) begin
            // Full scale on every source so both sums wrap
            speaker_i = 1'b1;
            sprite_audio_i = '1;
            synth_left_i = '1;
            synth_right_i = '1;
            i2s_left_i = '1;
            i2s_right_i = '1;
            wrap_cnt++;
        end else begin
            speaker_i = 1'($urandom);
            sprite_audio_i = AUDIO_SRC_W'($urandom);
            synth_left_i = AUDIO_SRC_W'($urandom);
            synth_right_i = AUDIO_SRC_W'($urandom);
            i2s_left_i = audio_sample_t'($urandom);
            i2s_right_i = audio_sample_t'($urandom);
        end
        if (speaker_i) speaker_cnt++;
    endtask

    task automatic drive_video();
        scanlines_en_i = 1'($urandom);
        screen_y_i = SCREEN_COORD_W'($urandom);
        r_i = color_t'($urandom);
        g_i = color_t'($urandom);
        b_i = color_t'($urandom);
        if (scanlines_en_i && screen_y_i[0]) dim_cnt++;
        else pass_cnt++;
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        {a2_phi1_i, a2_q3_i, a2_7m_i} = 3'b000;
        card_rd_en_i = '0;
        card_irq_n_i = '1;
        {serial_data_i, sprite_data_i, synth_data_i, bus_data_i} = '0;
        {speaker_i, sprite_audio_i, synth_left_i, synth_right_i} = '0;
        {i2s_left_i, i2s_right_i} = '0;
        {scanlines_en_i, screen_y_i, r_i, g_i, b_i} = '0;
        clk_level = '0;
        glitch_on = '0;
        @(posedge system_reset_n_w);
        repeat (RANDOM_CYCLES) begin
            @(posedge clk_logic_w);
            #(DRIVE_DELAY_NS);
            drive_bus_clocks();
            drive_card_bus();
            drive_audio();
            drive_video();
        end
        repeat (DRAIN_CYCLES) @(posedge clk_logic_w);
        require_seen(arb_case_cnt[0], "a serial card win");
        require_seen(arb_case_cnt[1], "a sprite card win");
        require_seen(arb_case_cnt[2], "a synthesizer card win");
        require_seen(arb_case_cnt[3], "a cycle with no card enabled");
        require_seen(arb_case_cnt[4], "several cards enabled together");
        require_seen(wrap_cnt, "a wrapping audio sum");
        require_seen(speaker_cnt, "an active speaker bit");
        require_seen(dim_cnt * pass_cnt, "both dimmed and plain pixels");
        require_seen(glitch_cnt, "a bus clock glitch");
        require_seen(toggle_cnt[0] * toggle_cnt[1] * toggle_cnt[2], "edges on all bus clocks");
        $display("All tests passed");
        $finish;
    end

    // Reset values are checked one falling edge after release
    initial begin
        @(posedge system_reset_n_w);
        @(negedge clk_logic_w);
        assert (data_dir_o == 1'b0 && irq_n_o == 1'b1 && data_o == '0)
            else report_mismatch("arbiter outputs not at their reset values");
        assert (audio_left_o == '0 && audio_right_o == '0)
            else report_mismatch("audio samples not zero after reset");
        assert ({r_o, g_o, b_o} == '0) else report_mismatch("colors not zero after reset");
        assert (pulses_w == '0 && phi1_o == 1'b0)
            else report_mismatch("clock level or edge pulses not zero after reset");
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_failure("Watchdog expired before the test sequence finished");
    end

endmodule

/* a2_card_glue.f */
hw/a2_glue_pkg.sv
hw/bus_clock_sync.sv
hw/card_bus_arbiter.sv
hw/audio_mixer.sv
hw/scanline_dimmer.sv
hw/a2_card_glue.sv
tb/tb_clock_gen.sv
tb/a2_card_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the a2_card_glue testbench with Verilator
# Run from the project root

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    --top-module a2_card_glue_tb \
    -f a2_card_glue.f \
    -o a2_card_glue_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/a2_card_glue_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "Some tests failed" "$SIM_LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" "$SIM_LOG" \
    || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
